// File: Bender.yml
package:
  name: lpif_link

sources:
  - logic/lpif_link_pkg.sv
  - logic/phy_lane_pkg.sv
  - logic/link_auto_sync.sv
  - logic/lane_tx_stripe.sv
  - logic/lane_rx_gather.sv
  - logic/lpif_link_top.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/lpif_link_assert.sv
      - test/lpif_link_tb.sv

// File: logic/lane_rx_gather.sv
////////////////////////////////////////////////////////////
// Lane rx gather
// Checks lane strobes, rebuilds the downstream LPIF beat
// and counts strobe errors for rx debug status
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_rx_gather (
  input  logic                          clk_wr,
  input  logic                          arst_n,
  input  logic                          rx_online_delay,
  input  phy_lane_pkg::phy_bus_t        rx_phy,
  output lpif_link_pkg::lpif_stream_t   dstrm,
  output phy_lane_pkg::debug_status_t   rx_debug_status
);

  ////////////////////////////////////////////////////////////
  // Lane unpack

  // Payload fields of all lanes, lane 0 lowest
  logic [phy_lane_pkg::NUM_LANES*phy_lane_pkg::LANE_PAYLOAD_W-1:0] payload_flat;

  // Strobe bit of each lane
  logic [phy_lane_pkg::NUM_LANES-1:0] lane_strobe;

  // Beat rebuilt from the payload
  lpif_link_pkg::lpif_stream_t beat_d;

  // All strobes present
  logic strobe_ok;

  // Saturating strobe error count
  phy_lane_pkg::debug_status_t err_cnt_q;

  always_comb begin : p_unpack
    phy_lane_pkg::lane_word_t lane_word;

    payload_flat = '0;
    lane_strobe  = '0;
    for (int n = 0; n < phy_lane_pkg::NUM_LANES; n++) begin
      lane_word = rx_phy[n*phy_lane_pkg::LANE_W +: phy_lane_pkg::LANE_W];
      payload_flat[n*phy_lane_pkg::LANE_PAYLOAD_W +: phy_lane_pkg::LANE_PAYLOAD_W] =
        lane_word[0 +: phy_lane_pkg::LANE_PAYLOAD_W];
      lane_strobe[n] = lane_word[phy_lane_pkg::STROBE_BIT];
    end
  end

  // Low 273 payload bits form the beat
  // Lane 7 padding and marker bits are ignored
  assign beat_d = payload_flat[lpif_link_pkg::LPIF_BEAT_W-1:0];

  ////////////////////////////////////////////////////////////
  // Strobe check

  // Beat is whole only if every lane carries its strobe
  assign strobe_ok = &lane_strobe;

  ////////////////////////////////////////////////////////////
  // Downstream register

  // One cycle from rx_phy to dstrm
  // Zero beat when offline or any strobe missing
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      dstrm <= '0;
    end else if (rx_online_delay && strobe_ok) begin
      dstrm <= beat_d;
    end else begin
      dstrm <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Error counter

  // Counts only while rx is online
  // Sticks at all ones
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      err_cnt_q <= '0;
    end else if (rx_online_delay && !strobe_ok && (err_cnt_q != '1)) begin
      err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

  // Count is the whole debug word
  assign rx_debug_status = err_cnt_q;

endmodule

// File: logic/lane_tx_stripe.sv
////////////////////////////////////////////////////////////
// Lane tx stripe
// Stripes the upstream LPIF beat over eight PHY lane words
// with a persistent strobe bit and a zero marker
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_tx_stripe (
  input  logic                        clk_wr,
  input  logic                        arst_n,
  input  logic                        tx_online_delay,
  input  lpif_link_pkg::lpif_stream_t ustrm,
  output phy_lane_pkg::phy_bus_t      tx_phy
);

  ////////////////////////////////////////////////////////////
  // Payload layout

  // Beat placed low-first over all lane payload fields
  // Top 31 bits land in lane 7 and stay zero
  logic [phy_lane_pkg::NUM_LANES*phy_lane_pkg::LANE_PAYLOAD_W-1:0] payload_flat;

  // Next PHY bus value while online
  phy_lane_pkg::phy_bus_t tx_phy_d;

  always_comb begin
    payload_flat = '0;
    payload_flat[lpif_link_pkg::LPIF_BEAT_W-1:0] = ustrm;
  end

  ////////////////////////////////////////////////////////////
  // Lane word build

  always_comb begin : p_stripe
    phy_lane_pkg::lane_word_t lane_word;

    tx_phy_d = '0;
    for (int n = 0; n < phy_lane_pkg::NUM_LANES; n++) begin
      lane_word = '0;
      // Payload slice for this lane
      lane_word[0 +: phy_lane_pkg::LANE_PAYLOAD_W] =
        payload_flat[n*phy_lane_pkg::LANE_PAYLOAD_W +: phy_lane_pkg::LANE_PAYLOAD_W];
      // Strobe set on every lane, every beat
      lane_word[phy_lane_pkg::STROBE_BIT] = 1'b1;
      // No user marker in this link
      lane_word[phy_lane_pkg::MARKER_BIT] = 1'b0;
      tx_phy_d[n*phy_lane_pkg::LANE_W +: phy_lane_pkg::LANE_W] = lane_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register

  // One cycle from ustrm to tx_phy
  // Lanes go quiet while tx is not yet online
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else if (tx_online_delay) begin
      tx_phy <= tx_phy_d;
    end else begin
      tx_phy <= '0;
    end
  end

endmodule

// File: logic/link_auto_sync.sv
////////////////////////////////////////////////////////////
// Link auto sync
// Delays tx and rx online by programmable clock counts,
// standing in for word-alignment time before traffic
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module link_auto_sync (
  input  logic                 clk_wr,
  input  logic                 arst_n,
  input  logic                 tx_online,
  input  logic                 rx_online,
  input  phy_lane_pkg::delay_t tx_delay,
  input  phy_lane_pkg::delay_t rx_delay,
  output logic                 tx_online_delay,
  output logic                 rx_online_delay
);

  // Per-direction sequencing FSM
  typedef enum logic [1:0] {
    OFFLINE = 2'd0,
    WAIT    = 2'd1,
    ONLINE  = 2'd2
  } sync_state_t;

  ////////////////////////////////////////////////////////////
  // Channel fan-in

  // Index 0 is tx, index 1 is rx
  logic                 online_in  [2];
  phy_lane_pkg::delay_t delay_in   [2];
  logic                 online_out [2];

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_in[0]  = tx_delay;
  assign delay_in[1]  = rx_delay;

  ////////////////////////////////////////////////////////////
  // Delay counters

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    sync_state_t          state_q;
    phy_lane_pkg::delay_t cnt_q;

    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        state_q <= OFFLINE;
        cnt_q   <= '0;
      end else if (!online_in[ch]) begin
        // Input low drops the flag at once
        state_q <= OFFLINE;
        cnt_q   <= '0;
      end else begin
        unique case (state_q)
          // First edge with input high starts the count
          OFFLINE: begin
            state_q <= WAIT;
            cnt_q   <= '0;
          end
          // Go online delay+1 edges after the start
          WAIT: begin
            if (cnt_q >= delay_in[ch]) begin
              state_q <= ONLINE;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
          // Hold until input drops
          ONLINE: begin
            state_q <= ONLINE;
          end
          default: begin
            state_q <= OFFLINE;
            cnt_q   <= '0;
          end
        endcase
      end
    end

    // Flag decoded from the state register
    assign online_out[ch] = (state_q == ONLINE);
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

endmodule

// File: logic/lpif_link_pkg.sv
////////////////////////////////////////////////////////////
// LPIF user-side types
// Field widths and the packed beat moved once per clock
////////////////////////////////////////////////////////////

package lpif_link_pkg;

  ////////////////////////////////////////////////////////////
  // Field types

  // Link state reported with every beat
  typedef logic [3:0] lpif_state_t;

  // Protocol id of the carried flit
  typedef logic [1:0] lpif_protid_t;

  // Flit data
  typedef logic [255:0] lpif_data_t;

  // CRC over the flit data
  typedef logic [7:0] lpif_crc_t;

  ////////////////////////////////////////////////////////////
  // Beat

  // One upstream or downstream beat
  // Valid bits are plain data here, no handshake
  // First field lands in the top bits, valid is bit 0
  typedef struct packed {
    lpif_state_t  state;
    lpif_protid_t protid;
    lpif_data_t   data;
    logic         dvalid;
    lpif_crc_t    crc;
    logic         crc_valid;
    logic         valid;
  } lpif_stream_t;

  // Beat width in bits
  // 4 + 2 + 256 + 1 + 8 + 1 + 1
  localparam int unsigned LPIF_BEAT_W = 273;

endpackage

// File: logic/lpif_link_top.sv
////////////////////////////////////////////////////////////
// LPIF link top
// Eight-lane LPIF-over-AIB endpoint, FIFO and credit bypassed
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lpif_link_top (
  input  logic                        clk_wr,
  input  logic                        arst_n,

  // Link control
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  phy_lane_pkg::delay_t        tx_delay,
  input  phy_lane_pkg::delay_t        rx_delay,

  // User side, one beat per clock each way
  input  lpif_link_pkg::lpif_stream_t ustrm,
  output lpif_link_pkg::lpif_stream_t dstrm,

  // PHY side
  output phy_lane_pkg::phy_bus_t      tx_phy,
  input  phy_lane_pkg::phy_bus_t      rx_phy,

  // Debug
  output phy_lane_pkg::debug_status_t rx_debug_status
);

  ////////////////////////////////////////////////////////////
  // Internal wires

  // Online flags after alignment delay
  logic tx_online_delay;
  logic rx_online_delay;

  ////////////////////////////////////////////////////////////
  // Auto sync

  link_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_delay        (tx_delay),
    .rx_delay        (rx_delay),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////////////////////////////////////////////
  // Datapath

  // Upstream beat onto the lanes
  lane_tx_stripe u_tx_stripe (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online_delay (tx_online_delay),
    .ustrm           (ustrm),
    .tx_phy          (tx_phy)
  );

  // Lanes back into the downstream beat
  lane_rx_gather u_rx_gather (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .rx_online_delay (rx_online_delay),
    .rx_phy          (rx_phy),
    .dstrm           (dstrm),
    .rx_debug_status (rx_debug_status)
  );

endmodule

// File: logic/phy_lane_pkg.sv
////////////////////////////////////////////////////////////
// PHY lane types
// Lane count, lane word layout and PHY-side bus widths
////////////////////////////////////////////////////////////

package phy_lane_pkg;

  // Eight AIB lanes in the link
  localparam int unsigned NUM_LANES = 8;

  // Lane word and its payload field
  localparam int unsigned LANE_W         = 40;
  localparam int unsigned LANE_PAYLOAD_W = 38;

  // Framing bits above the payload
  // Strobe is persistent, marker unused and held at zero
  localparam int unsigned STROBE_BIT = 38;
  localparam int unsigned MARKER_BIT = 39;

  // One lane word
  typedef logic [LANE_W-1:0] lane_word_t;

  // All lanes side by side, lane n from bit 40n upward
  typedef logic [NUM_LANES*LANE_W-1:0] phy_bus_t;

  // Online delay in clocks
  typedef logic [15:0] delay_t;

  // Debug status word
  typedef logic [31:0] debug_status_t;

endpackage

// File: lpif_link_top.f
logic/lpif_link_pkg.sv
logic/phy_lane_pkg.sv
logic/link_auto_sync.sv
logic/lane_tx_stripe.sv
logic/lane_rx_gather.sv
logic/lpif_link_top.sv
test/clk_gen.sv
test/lpif_link_assert.sv
test/lpif_link_tb.sv

// File: test/clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset
// 4 ns clock, reset held low for 10 cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clk_gen (
  output logic clk_wr,
  output logic arst_n
);

  // 2 ns half period
  initial begin
    clk_wr = 1'b0;
    forever #2 clk_wr = ~clk_wr;
  end

  // Release away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk_wr);
    @(negedge clk_wr);
    arst_n = 1'b1;
  end

endmodule

// File: test/lpif_link_assert.sv
////////////////////////////////////////////////////////////
// LPIF link assertions
// Lane quiet when offline, marker clear, error count monotonic
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lpif_link_assert (
  input logic                        clk_wr,
  input logic                        arst_n,
  input logic                        tx_online,
  input phy_lane_pkg::phy_bus_t      tx_phy,
  input phy_lane_pkg::debug_status_t rx_debug_status
);

  // Failed assertions, read by the testbench
  int unsigned fail_count = 0;

  // Marker bit of each lane
  logic [phy_lane_pkg::NUM_LANES-1:0] marker_bits;

  always_comb begin
    for (int n = 0; n < phy_lane_pkg::NUM_LANES; n++) begin
      marker_bits[n] = tx_phy[n*phy_lane_pkg::LANE_W + phy_lane_pkg::MARKER_BIT];
    end
  end

  // Input low drops the delayed flag, then the lane register clears
  tx_quiet_a: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !tx_online |-> ##2 (tx_phy == '0))
    else begin
      fail_count++;
      $error("tx_phy not zero after tx offline");
    end

  // No user markers on this link
  marker_clear_a: assert property (@(posedge clk_wr) disable iff (!arst_n)
    marker_bits == '0)
    else begin
      fail_count++;
      $error("marker bit set on tx_phy");
    end

  // Saturating count only moves up
  err_count_up_a: assert property (@(posedge clk_wr) disable iff (!arst_n)
    rx_debug_status >= $past(rx_debug_status))
    else begin
      fail_count++;
      $error("rx_debug_status decreased");
    end

endmodule

bind lpif_link_top lpif_link_assert u_assert (
  .clk_wr          (clk_wr),
  .arst_n          (arst_n),
  .tx_online       (tx_online),
  .tx_phy          (tx_phy),
  .rx_debug_status (rx_debug_status)
);

// File: test/lpif_link_tb.sv
////////////////////////////////////////////////////////////
// LPIF link testbench
// Table-driven loopback through an injection mask,
// checked against a cycle model of the lane rules
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lpif_link_tb;

  // One table row
  typedef struct packed {
    logic                   tx_on;
    logic                   rx_on;
    phy_lane_pkg::delay_t   tx_dly;
    phy_lane_pkg::delay_t   rx_dly;
    logic                   lock_check;
    phy_lane_pkg::phy_bus_t mask;
    logic [15:0]            beats;
  } test_entry_t;

  logic clk_wr;
  logic arst_n;
  logic tx_online;
  logic rx_online;
  phy_lane_pkg::delay_t tx_delay;
  phy_lane_pkg::delay_t rx_delay;
  lpif_link_pkg::lpif_stream_t ustrm;
  lpif_link_pkg::lpif_stream_t dstrm;
  phy_lane_pkg::phy_bus_t tx_phy;
  phy_lane_pkg::phy_bus_t rx_phy;
  phy_lane_pkg::phy_bus_t inj_mask;
  phy_lane_pkg::debug_status_t rx_debug_status;

  test_entry_t tests[$];
  logic        table_ready = 1'b0;
  integer      seed = 32'h6851;
  int          checks = 0;
  int          errors = 0;
  int          test_errs;

  ////////////////////////////////////////////////////////////
  // Reference model state

  int                          m_tx_run = 0;
  int                          m_rx_run = 0;
  logic                        m_tx_on = 1'b0;
  logic                        m_rx_on = 1'b0;
  phy_lane_pkg::phy_bus_t      m_tx_phy = '0;
  phy_lane_pkg::debug_status_t m_err = '0;
  lpif_link_pkg::lpif_stream_t exp_q[$];

  clk_gen u_clk (.clk_wr(clk_wr), .arst_n(arst_n));

  // PHY loopback with lane corruption
  assign rx_phy = tx_phy ^ inj_mask;

  lpif_link_top dut0 (
    .clk_wr(clk_wr), .arst_n(arst_n), .tx_online(tx_online), .rx_online(rx_online),
    .tx_delay(tx_delay), .rx_delay(rx_delay), .ustrm(ustrm), .dstrm(dstrm),
    .tx_phy(tx_phy), .rx_phy(rx_phy), .rx_debug_status(rx_debug_status)
  );

  ////////////////////////////////////////////////////////////
  // Lane layout helpers

  // Beat bit b goes to lane b/38, payload position b%38
  function automatic phy_lane_pkg::phy_bus_t stripe_beat(lpif_link_pkg::lpif_stream_t beat);
    phy_lane_pkg::phy_bus_t bus;
    bus = '0;
    for (int b = 0; b < lpif_link_pkg::LPIF_BEAT_W; b++) begin
      bus[(b / 38) * 40 + (b % 38)] = beat[b];
    end
    for (int n = 0; n < 8; n++) begin
      bus[n * 40 + 38] = 1'b1;
    end
    return bus;
  endfunction

  function automatic lpif_link_pkg::lpif_stream_t gather_beat(phy_lane_pkg::phy_bus_t bus);
    lpif_link_pkg::lpif_stream_t beat;
    for (int b = 0; b < lpif_link_pkg::LPIF_BEAT_W; b++) begin
      beat[b] = bus[(b / 38) * 40 + (b % 38)];
    end
    return beat;
  endfunction

  function automatic logic strobes_ok(phy_lane_pkg::phy_bus_t bus);
    logic ok;
    ok = 1'b1;
    for (int n = 0; n < 8; n++) begin
      ok &= bus[n * 40 + 38];
    end
    return ok;
  endfunction

  function automatic lpif_link_pkg::lpif_stream_t next_random_beat();
    logic [287:0] raw;
    for (int w = 0; w < 9; w++) begin
      raw[w*32 +: 32] = $random(seed);
    end
    return raw[lpif_link_pkg::LPIF_BEAT_W-1:0];
  endfunction

  task automatic add_test(input logic tx_on, input logic rx_on, input int tx_dly,
                          input int rx_dly, input logic lock_check,
                          input phy_lane_pkg::phy_bus_t mask, input int beats);
    test_entry_t t;
    t = '{tx_on, rx_on, tx_dly[15:0], rx_dly[15:0], lock_check, mask, beats[15:0]};
    tests.push_back(t);
  endtask

  task automatic check_value(input string name, input logic [319:0] expected,
                             input logic [319:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
      test_errs++;
    end
  endtask

  // One rising edge of the model, from the inputs being sampled
  task automatic step_model();
    phy_lane_pkg::phy_bus_t rx_m;
    rx_m = m_tx_phy ^ inj_mask;
    exp_q.push_back((m_rx_on && strobes_ok(rx_m)) ? gather_beat(rx_m) : '0);
    if (m_rx_on && !strobes_ok(rx_m) && (m_err != '1)) begin
      m_err = m_err + 1;
    end
    m_tx_phy = m_tx_on ? stripe_beat(ustrm) : '0;
    // Flag rises delay+1 edges after the first high sample
    m_tx_run = tx_online ? m_tx_run + 1 : 0;
    m_rx_run = rx_online ? m_rx_run + 1 : 0;
    m_tx_on  = tx_online && (m_tx_run >= int'(tx_delay) + 2);
    m_rx_on  = rx_online && (m_rx_run >= int'(rx_delay) + 2);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : p_main
    test_entry_t t;
    lpif_link_pkg::lpif_stream_t exp_d;
    int tx_first;
    int rx_first;
    tx_online = 1'b0;
    rx_online = 1'b0;
    tx_delay  = '0;
    rx_delay  = '0;
    ustrm     = '0;
    inj_mask  = '0;
    // Offline, lock, stream, lane 3 strobe loss, ignored bits, tx drop, all off, relock
    add_test(0, 0, 0, 0, 0, '0, 6);
    add_test(1, 1, 3, 6, 1, '0, 16);
    add_test(1, 1, 3, 6, 0, '0, 40);
    add_test(1, 1, 3, 6, 0, phy_lane_pkg::phy_bus_t'(1) << (3*40 + 38), 5);
    add_test(1, 1, 3, 6, 0, (phy_lane_pkg::phy_bus_t'(1) << (7*40 + 39)) |
             (phy_lane_pkg::phy_bus_t'(1) << (7*40 + 37)) |
             (phy_lane_pkg::phy_bus_t'(1) << (7*40 + 8)), 10);
    add_test(0, 1, 3, 6, 0, '0, 6);
    add_test(0, 0, 3, 6, 0, '0, 4);
    add_test(1, 1, 0, 2, 1, '0, 12);
    table_ready = 1'b1;
    wait (arst_n === 1'b1);
    check_value("tx_phy", '0, tx_phy);
    check_value("dstrm", '0, dstrm);
    check_value("rx_debug_status", '0, rx_debug_status);
    for (int i = 0; i < tests.size(); i++) begin
      t = tests[i];
      test_errs = 0;
      tx_first  = -1;
      rx_first  = -1;
      for (int c = 0; c < t.beats; c++) begin
        @(posedge clk_wr);
        step_model();
        tx_online <= t.tx_on;
        rx_online <= t.rx_on;
        tx_delay  <= t.tx_dly;
        rx_delay  <= t.rx_dly;
        inj_mask  <= t.mask;
        ustrm     <= next_random_beat();
        @(negedge clk_wr);
        exp_d = exp_q.pop_front();
        check_value("tx_phy", m_tx_phy, tx_phy);
        check_value("dstrm", exp_d, dstrm);
        check_value("rx_debug_status", m_err, rx_debug_status);
        if ((tx_first < 0) && tx_phy[phy_lane_pkg::STROBE_BIT]) begin
          tx_first = c;
        end
        if ((rx_first < 0) && (dstrm != '0)) begin
          rx_first = c;
        end
      end
      // Table values are first sampled at the second edge of the test
      if (t.lock_check) begin
        check_value("tx_phy strobe lock cycles", t.tx_dly + 2, tx_first - 1);
        check_value("dstrm lock cycles", t.rx_dly + 2, rx_first - 1);
      end
      $display("test %0d: %0d cycles, %0d errors", i, t.beats, test_errs);
    end
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, dut0.u_assert.fail_count);
    if ((errors == 0) && (dut0.u_assert.fail_count == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Reset, all beats and delays at 4 ns per cycle, plus margin
  initial begin : p_watchdog
    int unsigned limit;
    wait (table_ready);
    limit = 10 + 50;
    foreach (tests[i]) begin
      limit += tests[i].beats + tests[i].tx_dly + tests[i].rx_dly;
    end
    #(limit * 4);
    $display("Watchdog expired after %0d cycles, run did not finish", limit);
    $display("Test failed");
    $finish;
  end

endmodule
